//--- hw/mipsPkg.sv
// Shared definitions for the four-stage MIPS subset core
// Widths, instruction encodings and pipeline register layouts
package mipsPkg;

	// Datapath and register file sizes
	localparam int dataW = 32;
	localparam int regAddrW = 5;

	// Instruction ROM geometry, word addressed
	localparam int romDepth = 64;
	localparam int romAddrW = 6;
	localparam string progFile = "program.hex";

	// Major opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opR    = 6'd0,
		opAddi = 6'd8,
		opOri  = 6'd13,
		opBeq  = 6'd4,
		opBne  = 6'd5
	} opcodeE;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnNor = 6'h27
	} functE;

	// Operations the ALU can perform
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluNor = 3'd4
	} aluOpE;

	// Decoded control bits carried into execute
	typedef struct packed {
		logic  regWrite;
		logic  aluSrcImm;
		logic  branchEq;
		logic  branchNe;
		aluOpE aluOp;
	} ctrlT;

	// IF/ID pipeline register
	typedef struct packed {
		logic              valid;
		logic [dataW-1:0]  pc4;
		logic [dataW-1:0]  instr;
	} ifIdT;

	// ID/EX pipeline register
	typedef struct packed {
		logic                valid;
		ctrlT                ctrl;
		logic [dataW-1:0]    pc4;
		logic [dataW-1:0]    readData1;
		logic [dataW-1:0]    readData2;
		logic [dataW-1:0]    imm;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] writeReg;
	} idExT;

	// EX/WB pipeline register, also the writeback port
	typedef struct packed {
		logic                valid;
		logic                regWrite;
		logic [regAddrW-1:0] writeReg;
		logic [dataW-1:0]    aluResult;
	} exWbT;

endpackage

//--- hw/fetchStage.sv
// Fetch stage of the MIPS subset core
// Program counter, instruction ROM and the IF/ID register
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; (
	input  logic             clk,
	input  logic             rstN,
	input  logic             branchTaken,
	input  logic [dataW-1:0] branchTarget,
	input  logic             flush,
	output ifIdT             ifId
);

	logic [dataW-1:0] pc;
	logic [dataW-1:0] pcPlus4;
	logic [dataW-1:0] instr;
	logic [romAddrW-1:0] romIdx;

	// Program image, loaded at elaboration
	logic [dataW-1:0] rom [romDepth];

	initial begin
		$readmemh(progFile, rom);
	end

	// Word address from the byte PC
	assign romIdx = pc[romAddrW+1:2];
	assign instr = rom[romIdx];
	assign pcPlus4 = pc + dataW'(4);

	// PC moves every cycle, redirect wins over sequential
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else begin
			pc <= pcPlus4;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		ifId.pc4 <= pcPlus4;
		ifId.instr <= instr;
		// Taken branch kills the word fetched this cycle
		if (!rstN) begin
			ifId.valid <= 1'b0;
		end else begin
			ifId.valid <= ~flush;
		end
	end

endmodule

//--- hw/decodeStage.sv
// Decode stage of the MIPS subset core
// Control decode, immediate extension, register file and the ID/EX register
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  ifIdT ifId,
	input  exWbT exWb,
	input  logic flush,
	output idExT idEx
);

	// Instruction fields
	opcodeE              opcode;
	functE               funct;
	logic [regAddrW-1:0] rs;
	logic [regAddrW-1:0] rt;
	logic [regAddrW-1:0] rd;
	logic [15:0]         immRaw;

	ctrlT                ctrl;
	logic                known;
	logic [dataW-1:0]    immExt;
	logic [regAddrW-1:0] writeReg;
	logic [dataW-1:0]    readData1;
	logic [dataW-1:0]    readData2;
	logic                wbEn;

	// 32 architectural registers, entry 0 never written
	logic [dataW-1:0] regs [2**regAddrW];

	assign opcode = opcodeE'(ifId.instr[31:26]);
	assign funct = functE'(ifId.instr[5:0]);
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign immRaw = ifId.instr[15:0];

	// Control decode
	always_comb begin
		ctrl = '0;
		known = 1'b1;
		case (opcode)
			opR: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr:  ctrl.aluOp = aluOr;
					fnNor: ctrl.aluOp = aluNor;
					default: begin
						// Unsupported function, goes down as a bubble
						ctrl.regWrite = 1'b0;
						known = 1'b0;
					end
				endcase
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluOr;
			end
			// Branches compare in execute, ALU result unused
			opBeq: ctrl.branchEq = 1'b1;
			opBne: ctrl.branchNe = 1'b1;
			default: known = 1'b0;
		endcase
	end

	// ori zero-extends, everything else sign-extends
	assign immExt = (opcode == opOri) ? {16'b0, immRaw} : {{16{immRaw[15]}}, immRaw};

	// Destination is rd for R-type, rt for immediates
	assign writeReg = (opcode == opR) ? rd : rt;

	// Same condition as the top-level writeback event
	assign wbEn = exWb.valid & exWb.regWrite & (exWb.writeReg != '0);

	always_ff @(posedge clk) begin
		if (wbEn) begin
			regs[exWb.writeReg] <= exWb.aluResult;
		end
	end

	// Read port with write-first bypass and hardwired zero
	function automatic logic [dataW-1:0] regRead(input logic [regAddrW-1:0] addr);
		if (addr == '0) begin
			return '0;
		end else if (wbEn && exWb.writeReg == addr) begin
			return exWb.aluResult;
		end
		return regs[addr];
	endfunction

	assign readData1 = regRead(rs);
	assign readData2 = regRead(rt);

	// ID/EX register
	always_ff @(posedge clk) begin
		idEx.pc4 <= ifId.pc4;
		idEx.readData1 <= readData1;
		idEx.readData2 <= readData2;
		idEx.imm <= immExt;
		idEx.rs <= rs;
		idEx.rt <= rt;
		idEx.writeReg <= writeReg;
		if (!rstN) begin
			idEx.valid <= 1'b0;
			idEx.ctrl <= '0;
		end else begin
			idEx.valid <= ifId.valid & known & ~flush;
			idEx.ctrl <= ctrl;
		end
	end

endmodule

//--- hw/executeStage.sv
// Execute stage of the MIPS subset core
// Forwarding muxes, ALU, branch resolution and the EX/WB register
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
	input  logic             clk,
	input  logic             rstN,
	input  idExT             idEx,
	input  logic             fwdA,
	input  logic             fwdB,
	input  exWbT             exWb,
	output logic             branchTaken,
	output logic [dataW-1:0] branchTarget,
	output exWbT             exWbNext
);

	logic [dataW-1:0] opA;
	logic [dataW-1:0] opB;
	logic [dataW-1:0] aluB;
	logic [dataW-1:0] aluResult;
	logic             isBranch;
	logic             opEqual;

	// Distance-one dependences come from the EX/WB register
	assign opA = fwdA ? exWb.aluResult : idEx.readData1;
	assign opB = fwdB ? exWb.aluResult : idEx.readData2;

	// Second ALU input
	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd:  aluResult = opA + aluB;
			aluSub:  aluResult = opA - aluB;
			aluAnd:  aluResult = opA & aluB;
			aluOr:   aluResult = opA | aluB;
			aluNor:  aluResult = ~(opA | aluB);
			default: aluResult = '0;
		endcase
	end

	// Branch compare uses the register operand, never the immediate
	assign opEqual = (opA == opB);
	assign isBranch = idEx.ctrl.branchEq | idEx.ctrl.branchNe;

	assign branchTaken = idEx.valid &
		((idEx.ctrl.branchEq & opEqual) | (idEx.ctrl.branchNe & ~opEqual));

	// Word offset relative to the next sequential PC
	assign branchTarget = idEx.pc4 + {idEx.imm[dataW-3:0], 2'b00};

	// EX/WB register
	always_ff @(posedge clk) begin
		exWbNext.writeReg <= idEx.writeReg;
		exWbNext.aluResult <= aluResult;
		if (!rstN) begin
			exWbNext.valid <= 1'b0;
			exWbNext.regWrite <= 1'b0;
		end else begin
			// Branches retire without writing anything
			exWbNext.valid <= idEx.valid & ~isBranch;
			exWbNext.regWrite <= idEx.ctrl.regWrite & ~isBranch;
		end
	end

endmodule

//--- hw/hazardUnit.sv
// Hazard control for the MIPS subset core
// Forward select from EX/WB and flush of the younger stages on a taken branch
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  idExT idEx,
	input  exWbT exWb,
	input  logic branchTaken,
	output logic fwdA,
	output logic fwdB,
	output logic flush
);

	logic exWbWrites;

	// Older instruction will write a real register
	assign exWbWrites = exWb.valid & exWb.regWrite & (exWb.writeReg != '0);

	// Match against the sources of the instruction in execute
	assign fwdA = exWbWrites & (exWb.writeReg == idEx.rs);
	assign fwdB = exWbWrites & (exWb.writeReg == idEx.rt);

	// IF/ID and ID/EX hold wrong-path work after a taken branch
	assign flush = branchTaken;

endmodule

//--- hw/mipsProcessor.sv
// Top level of the four-stage MIPS subset core
// Connects fetch, decode, execute and hazard control, exposes writebacks
`timescale 1ns/1ps

module mipsProcessor import mipsPkg::*; (
	input  logic                clk,
	input  logic                rstN,
	output logic                wbValid,
	output logic [regAddrW-1:0] wbReg,
	output logic [dataW-1:0]    wbData
);

	// Pipeline registers between stages
	ifIdT ifId;
	idExT idEx;
	exWbT exWb;

	// Branch redirect and hazard controls
	logic             branchTaken;
	logic [dataW-1:0] branchTarget;
	logic             fwdA;
	logic             fwdB;
	logic             flush;

	fetchStage u_fetch (
		.clk(clk),
		.rstN(rstN),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.flush(flush),
		.ifId(ifId)
	);

	decodeStage u_decode (
		.clk(clk),
		.rstN(rstN),
		.ifId(ifId),
		.exWb(exWb),
		.flush(flush),
		.idEx(idEx)
	);

	// EX/WB output loops back for forwarding
	executeStage u_execute (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.exWb(exWb),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.exWbNext(exWb)
	);

	hazardUnit u_hazard (
		.idEx(idEx),
		.exWb(exWb),
		.branchTaken(branchTaken),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.flush(flush)
	);

	// Architectural register write, same as the register file enable
	assign wbValid = exWb.valid & exWb.regWrite & (exWb.writeReg != '0);
	assign wbReg = exWb.writeReg;
	assign wbData = exWb.aluResult;

endmodule

//--- dv/isaModel.svh
// Instruction-level reference model of the MIPS subset core
// Runs the program image in order and lists every register write

// One expected register write
typedef struct packed {
	logic [regAddrW-1:0] regIdx;
	logic [dataW-1:0]    value;
} wbPairT;

typedef wbPairT wbQueueT[$];

// Model copy of the program image
logic [dataW-1:0] progMem [romDepth];

function automatic wbQueueT runModel(output bit reachedEnd);
	wbQueueT             expQ;
	wbPairT              pair;
	logic [dataW-1:0]    regFile [32];
	logic [dataW-1:0]    pc;
	logic [dataW-1:0]    nextPc;
	logic [dataW-1:0]    instr;
	logic [dataW-1:0]    srcA;
	logic [dataW-1:0]    srcB;
	logic [dataW-1:0]    immS;
	logic [dataW-1:0]    result;
	opcodeE              op;
	functE               fn;
	logic [regAddrW-1:0] dest;
	logic                writes;
	int                  i;
	int                  step;

	// Unloaded words decode as an unknown opcode, tagged with their index
	for (i = 0; i < romDepth; i++) begin
		progMem[i] = {16'hfc00, 16'(i)};
	end
	$readmemh(progFile, progMem);
	for (i = 0; i < 32; i++) begin
		regFile[i] = '0;
	end

	reachedEnd = 1'b0;
	pc = '0;
	for (step = 0; step < 1000 && !reachedEnd; step++) begin
		instr = progMem[pc[romAddrW+1:2]];
		op = opcodeE'(instr[31:26]);
		fn = functE'(instr[5:0]);
		srcA = regFile[instr[25:21]];
		srcB = regFile[instr[20:16]];
		immS = {{16{instr[15]}}, instr[15:0]};
		nextPc = pc + 32'd4;
		writes = 1'b0;
		result = '0;
		dest = instr[20:16];
		case (op)
			opR: begin
				dest = instr[15:11];
				writes = 1'b1;
				case (fn)
					fnAdd: result = srcA + srcB;
					fnSub: result = srcA - srcB;
					fnAnd: result = srcA & srcB;
					fnOr:  result = srcA | srcB;
					fnNor: result = ~(srcA | srcB);
					// Unknown function retires as a no-op
					default: writes = 1'b0;
				endcase
			end
			opAddi: begin
				result = srcA + immS;
				writes = 1'b1;
			end
			// ori takes the raw 16 bits
			opOri: begin
				result = srcA | {16'b0, instr[15:0]};
				writes = 1'b1;
			end
			opBeq: begin
				if (srcA == srcB) begin
					nextPc = pc + 32'd4 + {immS[29:0], 2'b00};
				end
			end
			opBne: begin
				if (srcA != srcB) begin
					nextPc = pc + 32'd4 + {immS[29:0], 2'b00};
				end
			end
			default: writes = 1'b0;
		endcase
		// Register 0 stays zero and never shows as a write
		if (writes && dest != '0) begin
			regFile[dest] = result;
			pair.regIdx = dest;
			pair.value = result;
			expQ.push_back(pair);
		end
		// Branch to itself ends the program
		if (nextPc == pc) begin
			reachedEnd = 1'b1;
		end
		pc = nextPc;
	end
	return expQ;
endfunction

//--- dv/tbMips.sv
// Testbench for the MIPS subset core
// Compares every register writeback with an in-order ISA model
`timescale 1ns/1ps

module tbMips import mipsPkg::*; ();

	logic                clk;
	logic                rstN;
	logic                wbValid;
	logic [regAddrW-1:0] wbReg;
	logic [dataW-1:0]    wbData;

	`include "isaModel.svh"

	mipsProcessor u_dut (
		.clk(clk),
		.rstN(rstN),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// Reset held for 16 cycles and released just after an edge
	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		#1 rstN = 1'b1;
	end

	task automatic abortSim();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkReg(input logic [regAddrW-1:0] expReg,
			input logic [regAddrW-1:0] gotReg, input int idx);
		if (gotReg !== expReg) begin
			$display("** Error at %0t: writeback %0d register expected %0d, got %0d",
				$time, idx, expReg, gotReg);
			abortSim();
		end
	endtask

	task automatic checkData(input logic [dataW-1:0] expData,
			input logic [dataW-1:0] gotData, input int idx);
		if (gotData !== expData) begin
			$display("** Error at %0t: writeback %0d data expected %08h, got %08h",
				$time, idx, expData, gotData);
			abortSim();
		end
	endtask

	// No writeback may appear while reset is held
	task automatic idleDuringReset(input int limit);
		int cycles;
		cycles = 0;
		// First falling edge lies inside the reset window
		@(negedge clk);
		while (!rstN) begin
			if (wbValid) begin
				$display("A writeback appeared while reset was held");
				abortSim();
			end
			if (cycles >= limit) begin
				$display("Reset was never released within %0d cycles", limit);
				abortSim();
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	// Next writeback seen on a falling edge
	task automatic waitWriteback(input int idx, input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!wbValid) begin
			if (cycles >= limit) begin
				$display("Writeback %0d never arrived within %0d cycles", idx, limit);
				abortSim();
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	// Nothing more may be written once the self-loop is reached
	task automatic quietTail(input int span);
		int cycles;
		for (cycles = 0; cycles < span; cycles++) begin
			@(negedge clk);
			if (wbValid) begin
				$display("Extra writeback to register %0d after the program ended", wbReg);
				abortSim();
			end
		end
	endtask

	initial begin : compareProc
		wbQueueT expQ;
		wbPairT  expected;
		bit      modelDone;
		int      idx;

		expQ = runModel(modelDone);
		if (!modelDone || expQ.size() == 0) begin
			$display("Reference model found no writes or never reached the self-loop");
			abortSim();
		end
		idleDuringReset(40);
		// Only program order matters since branches add bubbles
		for (idx = 0; idx < expQ.size(); idx++) begin
			waitWriteback(idx, 100);
			expected = expQ[idx];
			checkReg(expected.regIdx, wbReg, idx);
			checkData(expected.value, wbData, idx);
		end
		quietTail(50);
		$display("Test OK");
		$finish;
	end

endmodule

//--- program.hex
// One 32-bit instruction word per line, word 0 first
// Hex word, then the assembly it encodes
20010005 // addi $1, $0, 5
2002fffd // addi $2, $0, -3
00221820 // add  $3, $1, $2
00612022 // sub  $4, $3, $1
34058001 // ori  $5, $0, 0x8001
00a23024 // and  $6, $5, $2
00c43825 // or   $7, $6, $4
00e04027 // nor  $8, $7, $0
20200007 // addi $0, $1, 7
00014820 // add  $9, $0, $1
00005027 // nor  $10, $0, $0
01415820 // add  $11, $10, $1
000a6022 // sub  $12, $0, $10
10220005 // beq  $1, $2, +5
14210005 // bne  $1, $1, +5
202d0001 // addi $13, $1, 1
11ad0002 // beq  $13, $13, +2
200e0063 // addi $14, $0, 99
200f0063 // addi $15, $0, 99
15a10002 // bne  $13, $1, +2
200e004d // addi $14, $0, 77
200f004d // addi $15, $0, 77
01ad7020 // add  $14, $13, $13
1000ffff // beq  $0, $0, -1

//--- build.f
+incdir+dv
hw/mipsPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/hazardUnit.sv
hw/mipsProcessor.sv
dv/tbMips.sv

//--- run.sh
#!/bin/sh
# Build the MIPS core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tbMips -o simMips
simOut=$(./obj_dir/simMips 2>&1) || true
echo "$simOut"
if echo "$simOut" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
